//--- hw/paCore_settings.svh
`ifndef PACORE_SETTINGS_SVH
`define PACORE_SETTINGS_SVH

// datapath widths
`define DATA_WIDTH 16
`define PC_WIDTH 16

// register file
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// instruction cache geometry
`define LINE_BYTES 32
`define LINE_WIDTH (`LINE_BYTES * 8)
`define CACHE_LINES 64
`define LINE_ADDR_WIDTH 6
`define CACHE_BYTES (`LINE_BYTES * `CACHE_LINES)

// fixed bundle size, also the pc step
`define BUNDLE_BYTES 8
`define BUNDLE_WIDTH (`BUNDLE_BYTES * 8)

`endif

//--- hw/paIsaPkg.sv
`include "paCore_settings.svh"

package paIsaPkg;

	// anything outside this list decodes as a no-op
	typedef enum logic [6:0]
	{
		OP_NOP = 7'd0,
		OP_ADD = 7'd1,
		OP_SUB = 7'd2,
		OP_AND = 7'd3,
		OP_OR  = 7'd4,
		OP_XOR = 7'd5,
		OP_SHL = 7'd6,
		OP_SHR = 7'd7
	} opcodeT;

	// register-register form, format bit clear
	typedef struct packed
	{
		logic format;
		opcodeT opcode;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`REG_ADDR_WIDTH-1:0] src;
		logic [13:0] reserved;
	} regRegT;

	// register-immediate form, format bit set
	typedef struct packed
	{
		logic format;
		opcodeT opcode;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [2:0] reserved;
		logic [`DATA_WIDTH-1:0] imm;
	} regImmT;

	// one instruction word, two ways to read it
	typedef union packed
	{
		regRegT regReg;
		regImmT regImm;
	} instrU;

	// slot A sits in the low half
	typedef struct packed
	{
		instrU slotB;
		instrU slotA;
	} bundleT;

endpackage

//--- hw/paPipePkg.sv
`include "paCore_settings.svh"

package paPipePkg;

	// one decoded lane, as handed to the register file
	typedef struct packed
	{
		logic valid;
		paIsaPkg::opcodeT opcode;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic srcRead;
		logic [`DATA_WIDTH-1:0] operand;
	} laneOpT;

	// alu status flags
	typedef struct packed
	{
		logic overflow;
		logic underflow;
	} statusT;

endpackage

//--- hw/instrCache.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module instrCache
(
	input logic clock_i,
	input logic reset_i,
	input logic [`LINE_ADDR_WIDTH-1:0] lineAddr_i,
	input logic writeEnable_i,
	input logic [`LINE_ADDR_WIDTH-1:0] writeLine_i,
	input logic [`LINE_WIDTH-1:0] writeData_i,
	output logic [`LINE_WIDTH-1:0] line_o,
	output logic lineValid_o
);

	logic [`LINE_WIDTH-1:0] lines [`CACHE_LINES];

	// loading port, also open while the core is in reset
	always_ff @(posedge clock_i)
	begin
		if (writeEnable_i)
		begin
			lines[writeLine_i] <= writeData_i;
		end
	end

	// fetch stage 1, registered line read
	always_ff @(posedge clock_i)
	begin
		line_o <= lines[lineAddr_i];
	end

	// fetch requests every cycle once out of reset
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			lineValid_o <= 1'b0;
		end
		else
		begin
			lineValid_o <= 1'b1;
		end
	end

endmodule

//--- hw/bundleFetch.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module bundleFetch
(
	input logic clock_i,
	input logic reset_i,
	input logic [`LINE_WIDTH-1:0] line_i,
	input logic lineValid_i,
	output logic [`LINE_ADDR_WIDTH-1:0] lineAddr_o,
	output logic [`PC_WIDTH-1:0] pc_o,
	output paIsaPkg::bundleT bundle_o,
	output logic bundleValid_o
);
	import paIsaPkg::*;

	localparam int bundleLsb = $clog2(`BUNDLE_BYTES);
	localparam int lineLsb = $clog2(`LINE_BYTES);

	logic [`PC_WIDTH-1:0] pc;
	logic [`PC_WIDTH-1:0] pcNext;
	logic [lineLsb-bundleLsb-1:0] bundleSel;

	assign pcNext = pc + `PC_WIDTH'(`BUNDLE_BYTES);
	assign lineAddr_o = pc[lineLsb +: `LINE_ADDR_WIDTH];
	assign pc_o = pc;

	// no branches, so the pc only steps forward and wraps at the cache end
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			pc <= '0;
		end
		else if (pcNext >= `PC_WIDTH'(`CACHE_BYTES))
		begin
			pc <= '0;
		end
		else
		begin
			pc <= pcNext;
		end
	end

	// offset delayed to line up with the returned line
	always_ff @(posedge clock_i)
	begin
		bundleSel <= pc[bundleLsb +: lineLsb - bundleLsb];
		bundle_o <= bundleT'(line_i[bundleSel * `BUNDLE_WIDTH +: `BUNDLE_WIDTH]);
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			bundleValid_o <= 1'b0;
		end
		else
		begin
			bundleValid_o <= lineValid_i;
		end
	end

endmodule

//--- hw/bundleParser.sv
`timescale 1ns/1ns

module bundleParser
(
	input logic clock_i,
	input logic reset_i,
	input paIsaPkg::bundleT bundle_i,
	input logic bundleValid_i,
	output paIsaPkg::instrU slotA_o,
	output paIsaPkg::instrU slotB_o,
	output logic slotValidA_o,
	output logic slotValidB_o
);

	logic slotUsedA;
	logic slotUsedB;

	// all-zero word means an empty slot
	assign slotUsedA = |bundle_i.slotA;
	assign slotUsedB = |bundle_i.slotB;

	always_ff @(posedge clock_i)
	begin
		slotA_o <= bundle_i.slotA;
		slotB_o <= bundle_i.slotB;
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			slotValidA_o <= 1'b0;
			slotValidB_o <= 1'b0;
		end
		else
		begin
			slotValidA_o <= bundleValid_i && slotUsedA;
			slotValidB_o <= bundleValid_i && slotUsedB;
		end
	end

endmodule

//--- hw/laneDecode.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module laneDecode
(
	input logic clock_i,
	input logic reset_i,
	input paIsaPkg::instrU instr_i,
	input logic instrValid_i,
	output paPipePkg::laneOpT laneOp_o
);
	import paIsaPkg::*;
	import paPipePkg::*;

	laneOpT decoded;
	logic knownOp;

	always_comb
	begin
		// opcode and dest sit at the same bits in both views
		knownOp = (instr_i.regReg.opcode != OP_NOP) && (instr_i.regReg.opcode <= OP_SHR);
		decoded.opcode = instr_i.regReg.opcode;
		decoded.dest = instr_i.regReg.dest;
		if (instr_i.regReg.format)
		begin
			decoded.srcRead = 1'b0;
			decoded.operand = instr_i.regImm.imm;
		end
		else
		begin
			decoded.srcRead = 1'b1;
			decoded.operand = `DATA_WIDTH'(instr_i.regReg.src);
		end
		// nop, unknown op or r0 target turns into a bubble
		decoded.valid = instrValid_i && knownOp && (instr_i.regReg.dest != '0);
	end

	always_ff @(posedge clock_i)
	begin
		laneOp_o <= decoded;
		if (reset_i)
		begin
			laneOp_o.valid <= 1'b0;
		end
	end

endmodule

//--- hw/registerFile.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module registerFile
(
	input logic clock_i,
	input logic reset_i,
	input paPipePkg::laneOpT laneOpA_i,
	input paPipePkg::laneOpT laneOpB_i,
	input logic wbEnableA_i,
	input logic wbEnableB_i,
	input logic [`REG_ADDR_WIDTH-1:0] wbAddrA_i,
	input logic [`REG_ADDR_WIDTH-1:0] wbAddrB_i,
	input logic [`DATA_WIDTH-1:0] wbDataA_i,
	input logic [`DATA_WIDTH-1:0] wbDataB_i,
	output logic issueValidA_o,
	output logic issueValidB_o,
	output paIsaPkg::opcodeT opcodeA_o,
	output paIsaPkg::opcodeT opcodeB_o,
	output logic [`REG_ADDR_WIDTH-1:0] destA_o,
	output logic [`REG_ADDR_WIDTH-1:0] destB_o,
	output logic [`DATA_WIDTH-1:0] operandPA_o,
	output logic [`DATA_WIDTH-1:0] operandSA_o,
	output logic [`DATA_WIDTH-1:0] operandPB_o,
	output logic [`DATA_WIDTH-1:0] operandSB_o
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
	logic [`DATA_WIDTH-1:0] readPA;
	logic [`DATA_WIDTH-1:0] readSA;
	logic [`DATA_WIDTH-1:0] readPB;
	logic [`DATA_WIDTH-1:0] readSB;

	////////////////////////////////////////
	// read ports

	// write-first bypass, lane b checked before lane a
	function automatic logic [`DATA_WIDTH-1:0] readReg(input logic [`REG_ADDR_WIDTH-1:0] addr);
		logic [`DATA_WIDTH-1:0] value;
		if (addr == '0)
		begin
			value = '0;
		end
		else if (wbEnableB_i && (wbAddrB_i == addr))
		begin
			value = wbDataB_i;
		end
		else if (wbEnableA_i && (wbAddrA_i == addr))
		begin
			value = wbDataA_i;
		end
		else
		begin
			value = regs[addr];
		end
		return value;
	endfunction

	// dest is also the primary operand
	always_comb
	begin
		readPA = readReg(laneOpA_i.dest);
		readPB = readReg(laneOpB_i.dest);
		readSA = laneOpA_i.srcRead ? readReg(laneOpA_i.operand[`REG_ADDR_WIDTH-1:0])
			: laneOpA_i.operand;
		readSB = laneOpB_i.srcRead ? readReg(laneOpB_i.operand[`REG_ADDR_WIDTH-1:0])
			: laneOpB_i.operand;
	end

	////////////////////////////////////////
	// write ports

	// lane b written last so it wins a clash
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			if (wbEnableA_i && (wbAddrA_i != '0))
			begin
				regs[wbAddrA_i] <= wbDataA_i;
			end
			if (wbEnableB_i && (wbAddrB_i != '0))
			begin
				regs[wbAddrB_i] <= wbDataB_i;
			end
		end
	end

	////////////////////////////////////////
	// issue register

	always_ff @(posedge clock_i)
	begin
		opcodeA_o <= laneOpA_i.opcode;
		opcodeB_o <= laneOpB_i.opcode;
		destA_o <= laneOpA_i.dest;
		destB_o <= laneOpB_i.dest;
		operandPA_o <= readPA;
		operandSA_o <= readSA;
		operandPB_o <= readPB;
		operandSB_o <= readSB;
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			issueValidA_o <= 1'b0;
			issueValidB_o <= 1'b0;
		end
		else
		begin
			issueValidA_o <= laneOpA_i.valid;
			issueValidB_o <= laneOpB_i.valid;
		end
	end

endmodule

//--- hw/arithmeticUnit.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module arithmeticUnit
(
	input logic clock_i,
	input logic reset_i,
	input logic enable_i,
	input paIsaPkg::opcodeT opcode_i,
	input logic [`REG_ADDR_WIDTH-1:0] dest_i,
	input logic [`DATA_WIDTH-1:0] operandP_i,
	input logic [`DATA_WIDTH-1:0] operandS_i,
	output logic wbEnable_o,
	output logic [`REG_ADDR_WIDTH-1:0] wbAddr_o,
	output logic [`DATA_WIDTH-1:0] wbData_o,
	output paPipePkg::statusT status_o
);
	import paIsaPkg::*;
	import paPipePkg::*;

	localparam int msb = `DATA_WIDTH - 1;

	logic [`DATA_WIDTH-1:0] result;
	logic [$clog2(`DATA_WIDTH)-1:0] shiftAmount;
	statusT status;

	assign shiftAmount = operandS_i[$clog2(`DATA_WIDTH)-1:0];

	always_comb
	begin
		result = '0;
		status = '0;
		case (opcode_i)
			OP_ADD:
			begin
				result = operandP_i + operandS_i;
				// like signs in, other sign out
				status.overflow = (operandP_i[msb] == operandS_i[msb])
					&& (result[msb] != operandP_i[msb]);
			end
			OP_SUB:
			begin
				result = operandP_i - operandS_i;
				status.underflow = (operandP_i[msb] != operandS_i[msb])
					&& (result[msb] != operandP_i[msb]);
			end
			OP_AND: result = operandP_i & operandS_i;
			OP_OR: result = operandP_i | operandS_i;
			OP_XOR: result = operandP_i ^ operandS_i;
			OP_SHL: result = operandP_i << shiftAmount;
			// logical shift, zero fill
			OP_SHR: result = operandP_i >> shiftAmount;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock_i)
	begin
		wbAddr_o <= dest_i;
		wbData_o <= result;
		status_o <= status;
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			wbEnable_o <= 1'b0;
		end
		else
		begin
			wbEnable_o <= enable_i;
		end
	end

endmodule

//--- hw/paCore.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module paCore
(
	input logic clock_i,
	input logic reset_i,
	input logic icacheWriteEnable_i,
	input logic [`LINE_ADDR_WIDTH-1:0] writeLine_i,
	input logic [`LINE_WIDTH-1:0] instruction_i,
	output logic [`PC_WIDTH-1:0] pc_o,
	output logic wbEnableA_o,
	output logic [`REG_ADDR_WIDTH-1:0] wbAddrA_o,
	output logic [`DATA_WIDTH-1:0] wbDataA_o,
	output paPipePkg::statusT statusA_o,
	output logic wbEnableB_o,
	output logic [`REG_ADDR_WIDTH-1:0] wbAddrB_o,
	output logic [`DATA_WIDTH-1:0] wbDataB_o,
	output paPipePkg::statusT statusB_o
);
	import paIsaPkg::*;
	import paPipePkg::*;

	// fetch
	logic [`LINE_ADDR_WIDTH-1:0] lineAddr;
	logic [`LINE_WIDTH-1:0] line;
	logic lineValid;
	bundleT bundle;
	logic bundleValid;

	// parse and decode
	instrU slotA;
	instrU slotB;
	logic slotValidA;
	logic slotValidB;
	laneOpT laneOpA;
	laneOpT laneOpB;

	// issue
	logic issueValidA;
	logic issueValidB;
	opcodeT opcodeA;
	opcodeT opcodeB;
	logic [`REG_ADDR_WIDTH-1:0] destA;
	logic [`REG_ADDR_WIDTH-1:0] destB;
	logic [`DATA_WIDTH-1:0] operandPA;
	logic [`DATA_WIDTH-1:0] operandSA;
	logic [`DATA_WIDTH-1:0] operandPB;
	logic [`DATA_WIDTH-1:0] operandSB;

	////////////////////////////////////////
	// front end

	instrCache i_instrCache
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.lineAddr_i(lineAddr),
		.writeEnable_i(icacheWriteEnable_i),
		.writeLine_i(writeLine_i),
		.writeData_i(instruction_i),
		.line_o(line),
		.lineValid_o(lineValid)
	);

	bundleFetch i_bundleFetch
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.line_i(line),
		.lineValid_i(lineValid),
		.lineAddr_o(lineAddr),
		.pc_o(pc_o),
		.bundle_o(bundle),
		.bundleValid_o(bundleValid)
	);

	bundleParser i_bundleParser
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.bundle_i(bundle),
		.bundleValid_i(bundleValid),
		.slotA_o(slotA),
		.slotB_o(slotB),
		.slotValidA_o(slotValidA),
		.slotValidB_o(slotValidB)
	);

	laneDecode i_laneDecodeA
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.instr_i(slotA),
		.instrValid_i(slotValidA),
		.laneOp_o(laneOpA)
	);

	laneDecode i_laneDecodeB
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.instr_i(slotB),
		.instrValid_i(slotValidB),
		.laneOp_o(laneOpB)
	);

	////////////////////////////////////////
	// back end

	// alu results loop straight back into the write ports
	registerFile i_registerFile
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.laneOpA_i(laneOpA),
		.laneOpB_i(laneOpB),
		.wbEnableA_i(wbEnableA_o),
		.wbEnableB_i(wbEnableB_o),
		.wbAddrA_i(wbAddrA_o),
		.wbAddrB_i(wbAddrB_o),
		.wbDataA_i(wbDataA_o),
		.wbDataB_i(wbDataB_o),
		.issueValidA_o(issueValidA),
		.issueValidB_o(issueValidB),
		.opcodeA_o(opcodeA),
		.opcodeB_o(opcodeB),
		.destA_o(destA),
		.destB_o(destB),
		.operandPA_o(operandPA),
		.operandSA_o(operandSA),
		.operandPB_o(operandPB),
		.operandSB_o(operandSB)
	);

	arithmeticUnit i_arithmeticUnitA
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.enable_i(issueValidA),
		.opcode_i(opcodeA),
		.dest_i(destA),
		.operandP_i(operandPA),
		.operandS_i(operandSA),
		.wbEnable_o(wbEnableA_o),
		.wbAddr_o(wbAddrA_o),
		.wbData_o(wbDataA_o),
		.status_o(statusA_o)
	);

	arithmeticUnit i_arithmeticUnitB
	(
		.clock_i(clock_i),
		.reset_i(reset_i),
		.enable_i(issueValidB),
		.opcode_i(opcodeB),
		.dest_i(destB),
		.operandP_i(operandPB),
		.operandS_i(operandSB),
		.wbEnable_o(wbEnableB_o),
		.wbAddr_o(wbAddrB_o),
		.wbData_o(wbDataB_o),
		.status_o(statusB_o)
	);

endmodule

//--- tests/paCoreChecker.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module paCoreChecker
(
	input logic clock_i,
	input logic reset_i,
	input logic [`PC_WIDTH-1:0] pc_i,
	input logic wbEnableA_i,
	input logic [`REG_ADDR_WIDTH-1:0] wbAddrA_i,
	input logic [`DATA_WIDTH-1:0] wbDataA_i,
	input paPipePkg::statusT statusA_i,
	input logic wbEnableB_i,
	input logic [`REG_ADDR_WIDTH-1:0] wbAddrB_i,
	input logic [`DATA_WIDTH-1:0] wbDataB_i,
	input paPipePkg::statusT statusB_i,
	output int rowsChecked_o,
	output int rowsFailed_o,
	output int errorCount_o
);
	import paPipePkg::*;

	// one entry per row and lane, {enable, addr, data, status}
	logic [23:0] expectA [$];
	logic [23:0] expectB [$];
	int cycle;

	initial
	begin
		rowsChecked_o = 0;
		rowsFailed_o = 0;
		errorCount_o = 0;
		cycle = 0;
	end

	task automatic expectRow(input logic [23:0] laneA, input logic [23:0] laneB);
		expectA.push_back(laneA);
		expectB.push_back(laneB);
	endtask

	task automatic checkField(input string name, input logic [15:0] expected,
		input logic [15:0] actual, inout bit ok);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
			errorCount_o++;
			ok = 1'b0;
		end
	endtask

	task automatic checkLane(input string lane, input logic [23:0] expected, input logic en,
		input logic [4:0] addr, input logic [15:0] data, input logic [1:0] status,
		inout bit ok);
		checkField({"wbEnable", lane, "_o"}, 16'(expected[23]), 16'(en), ok);
		if (expected[23] && en)
		begin
			checkField({"wbAddr", lane, "_o"}, 16'(expected[22:18]), 16'(addr), ok);
			checkField({"wbData", lane, "_o"}, expected[17:2], data, ok);
			checkField({"status", lane, "_o"}, 16'(expected[1:0]), 16'(status), ok);
		end
	endtask

	// sampled mid-cycle, away from the edge where the DUT updates
	always @(negedge clock_i)
	begin
		bit ok;
		logic [23:0] laneA;
		logic [23:0] laneB;
		if (reset_i)
		begin
			cycle = 0;
		end
		else
		begin
			ok = 1'b1;
			if (cycle < 6 || expectA.size() > 0)
			begin
				checkField("pc_o", 16'(cycle * `BUNDLE_BYTES), 16'(pc_i), ok);
			end
			// pipeline still filling, nothing may write back
			if (cycle < 6)
			begin
				checkField("wbEnableA_o", 16'h0, 16'(wbEnableA_i), ok);
				checkField("wbEnableB_o", 16'h0, 16'(wbEnableB_i), ok);
			end
			else if (expectA.size() > 0)
			begin
				laneA = expectA.pop_front();
				laneB = expectB.pop_front();
				checkLane("A", laneA, wbEnableA_i, wbAddrA_i, wbDataA_i, statusA_i, ok);
				checkLane("B", laneB, wbEnableB_i, wbAddrB_i, wbDataB_i, statusB_i, ok);
				if (ok)
				begin
					$display("row %0d ok", rowsChecked_o);
				end
				else
				begin
					$display("row %0d mismatch", rowsChecked_o);
					rowsFailed_o++;
				end
				rowsChecked_o++;
			end
			cycle++;
		end
	end

endmodule

//--- tests/paCoreTb.sv
`timescale 1ns/1ns
`include "paCore_settings.svh"

module tbClock
(
	output logic clock_o
);

	initial
	begin
		clock_o = 1'b0;
	end

	always #10 clock_o = ~clock_o;

endmodule

module paCoreTb;

	localparam int rowCount = 22;
	localparam int pipeDepth = 6;
	localparam int resetCycles = 16;
	localparam int marginCycles = 40;
	localparam logic [6:0] opNop = 7'd0;
	localparam logic [6:0] opAdd = 7'd1;
	localparam logic [6:0] opSub = 7'd2;
	localparam logic [6:0] opAnd = 7'd3;
	localparam logic [6:0] opOr = 7'd4;
	localparam logic [6:0] opXor = 7'd5;
	localparam logic [6:0] opShl = 7'd6;
	localparam logic [6:0] opShr = 7'd7;

	typedef struct
	{
		logic [31:0] instrA;
		logic [31:0] instrB;
		bit randA;
		bit randB;
		logic [23:0] expectA;
		logic [23:0] expectB;
	} rowT;

	logic clock;
	logic reset;
	logic icacheWriteEnable;
	logic [`LINE_ADDR_WIDTH-1:0] writeLine;
	logic [`LINE_WIDTH-1:0] instruction;
	logic [`PC_WIDTH-1:0] pc;
	logic wbEnableA;
	logic [`REG_ADDR_WIDTH-1:0] wbAddrA;
	logic [`DATA_WIDTH-1:0] wbDataA;
	paPipePkg::statusT statusA;
	logic wbEnableB;
	logic [`REG_ADDR_WIDTH-1:0] wbAddrB;
	logic [`DATA_WIDTH-1:0] wbDataB;
	paPipePkg::statusT statusB;
	int rowsChecked;
	int rowsFailed;
	int errorCount;

	rowT rows [rowCount];
	logic [15:0] modelRegs [32];
	logic [31:0] lfsrState;

	tbClock i_clock(.clock_o(clock));

	paCore i_dut
	(
		.clock_i(clock),
		.reset_i(reset),
		.icacheWriteEnable_i(icacheWriteEnable),
		.writeLine_i(writeLine),
		.instruction_i(instruction),
		.pc_o(pc),
		.wbEnableA_o(wbEnableA),
		.wbAddrA_o(wbAddrA),
		.wbDataA_o(wbDataA),
		.statusA_o(statusA),
		.wbEnableB_o(wbEnableB),
		.wbAddrB_o(wbAddrB),
		.wbDataB_o(wbDataB),
		.statusB_o(statusB)
	);

	paCoreChecker i_checker
	(
		.clock_i(clock),
		.reset_i(reset),
		.pc_i(pc),
		.wbEnableA_i(wbEnableA),
		.wbAddrA_i(wbAddrA),
		.wbDataA_i(wbDataA),
		.statusA_i(statusA),
		.wbEnableB_i(wbEnableB),
		.wbAddrB_i(wbAddrB),
		.wbDataB_i(wbDataB),
		.statusB_i(statusB),
		.rowsChecked_o(rowsChecked),
		.rowsFailed_o(rowsFailed),
		.errorCount_o(errorCount)
	);

	////////////////////////////////////////
	// instruction encoding and random immediates

	function automatic logic [31:0] encodeRegReg(input logic [6:0] op, input logic [4:0] dest,
		input logic [4:0] src);
		return {1'b0, op, dest, src, 14'b0};
	endfunction

	function automatic logic [31:0] encodeRegImm(input logic [6:0] op, input logic [4:0] dest,
		input logic [15:0] imm);
		return {1'b1, op, dest, 3'b0, imm};
	endfunction

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic takeRandom16(output logic [15:0] value);
		value = '0;
		for (int i = 0; i < 16; i++)
		begin
			value = {value[14:0], lfsrState[0]};
			lfsrState = stepLfsr(lfsrState);
		end
	endtask

	task automatic setRow(input int idx, input logic [31:0] a, input logic [31:0] b,
		input bit ra, input bit rb);
		rows[idx].instrA = a;
		rows[idx].instrB = b;
		rows[idx].randA = ra;
		rows[idx].randB = rb;
	endtask

	// dependent bundles sit at least three rows after their producers
	task automatic buildTable();
		for (int i = 0; i < rowCount; i++)
		begin
			setRow(i, 32'h0, 32'h0, 1'b0, 1'b0);
		end
		setRow(0, encodeRegImm(opAdd, 5'd1, 16'h0), encodeRegImm(opOr, 5'd2, 16'h0), 1, 1);
		setRow(1, encodeRegImm(opAdd, 5'd3, 16'h7000), encodeRegImm(opAdd, 5'd4, 16'h9000), 0, 0);
		setRow(2, encodeRegImm(opOr, 5'd5, 16'h00f3), encodeRegImm(opAdd, 5'd6, 16'h0005), 0, 0);
		setRow(3, encodeRegReg(opSub, 5'd1, 5'd2), encodeRegReg(opAnd, 5'd2, 5'd1), 0, 0);
		setRow(4, encodeRegReg(opAdd, 5'd3, 5'd3), encodeRegReg(opSub, 5'd4, 5'd3), 0, 0);
		setRow(5, encodeRegReg(opXor, 5'd5, 5'd6), encodeRegReg(opShl, 5'd6, 5'd5), 0, 0);
		setRow(6, encodeRegImm(opShr, 5'd1, 16'h0004), 32'h0, 0, 0);
		// unknown opcode and a write to r0
		setRow(7, encodeRegImm(7'h55, 5'd7, 16'h1234), encodeRegImm(opAdd, 5'd0, 16'h1234), 0, 0);
		setRow(8, encodeRegImm(opNop, 5'd8, 16'h1111), 32'h0, 0, 0);
		// same target in both lanes
		setRow(9, encodeRegImm(opAdd, 5'd10, 16'h0), encodeRegImm(opAdd, 5'd10, 16'h0), 1, 1);
		// r0 read back late enough to see any write from row 7
		setRow(10, 32'h0, encodeRegReg(opXor, 5'd5, 5'd0), 0, 0);
		setRow(12, encodeRegReg(opOr, 5'd11, 5'd10), encodeRegReg(opSub, 5'd12, 5'd10), 0, 0);
		setRow(13, encodeRegImm(opAdd, 5'd13, 16'h0), encodeRegReg(opAnd, 5'd1, 5'd2), 1, 0);
		setRow(14, encodeRegImm(opShl, 5'd3, 16'h0), encodeRegImm(opShr, 5'd4, 16'h0), 1, 1);
		setRow(15, encodeRegReg(opSub, 5'd6, 5'd5), encodeRegReg(opXor, 5'd9, 5'd11), 0, 0);
		setRow(16, encodeRegReg(opAdd, 5'd12, 5'd12), encodeRegImm(opAdd, 5'd14, 16'h7fff), 0, 0);
		setRow(19, encodeRegImm(opAdd, 5'd14, 16'h0001), encodeRegReg(opSub, 5'd15, 5'd14), 0, 0);
		setRow(20, encodeRegReg(7'h7f, 5'd16, 5'd1), encodeRegImm(opOr, 5'd16, 16'h0), 0, 1);
	endtask

	////////////////////////////////////////
	// reference model

	// returns {enable, addr, data, status}
	// status packs {overflow, underflow}
	function automatic logic [23:0] modelLane(input logic [31:0] instr);
		logic [6:0] op;
		logic [4:0] dest;
		logic [4:0] src;
		logic [15:0] p;
		logic [15:0] s;
		logic [15:0] r;
		logic [1:0] status;
		int wide;
		op = instr[30:24];
		dest = instr[23:19];
		src = instr[18:14];
		p = (dest == 0) ? 16'h0 : modelRegs[dest];
		s = instr[31] ? instr[15:0] : ((src == 0) ? 16'h0 : modelRegs[src]);
		r = '0;
		status = 2'b00;
		if (instr == 0 || op == opNop || op > opShr || dest == 0)
		begin
			return 24'h0;
		end
		case (op)
			opAdd:
			begin
				r = p + s;
				wide = int'($signed(p)) + int'($signed(s));
				status[1] = (wide > 32767) || (wide < -32768);
			end
			opSub:
			begin
				r = p - s;
				wide = int'($signed(p)) - int'($signed(s));
				status[0] = (wide > 32767) || (wide < -32768);
			end
			opAnd: r = p & s;
			opOr: r = p | s;
			opXor: r = p ^ s;
			opShl: r = p << s[3:0];
			default: r = p >> s[3:0];
		endcase
		return {1'b1, dest, r, status};
	endfunction

	task automatic modelTable();
		logic [15:0] value;
		for (int i = 0; i < 32; i++)
		begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < rowCount; i++)
		begin
			if (rows[i].randA)
			begin
				takeRandom16(value);
				rows[i].instrA[15:0] = value;
			end
			if (rows[i].randB)
			begin
				takeRandom16(value);
				rows[i].instrB[15:0] = value;
			end
			// both lanes read the state before the bundle
			rows[i].expectA = modelLane(rows[i].instrA);
			rows[i].expectB = modelLane(rows[i].instrB);
			if (rows[i].expectA[23])
			begin
				modelRegs[rows[i].expectA[22:18]] = rows[i].expectA[17:2];
			end
			// lane b last so it wins
			if (rows[i].expectB[23])
			begin
				modelRegs[rows[i].expectB[22:18]] = rows[i].expectB[17:2];
			end
		end
	endtask

	// writes run ahead of the fetch, which needs four cycles per line
	task automatic loadCache();
		int idx;
		for (int line = 0; line < `CACHE_LINES; line++)
		begin
			@(posedge clock);
			#2;
			icacheWriteEnable = 1'b1;
			writeLine = line[`LINE_ADDR_WIDTH-1:0];
			instruction = '0;
			for (int j = 0; j < 4; j++)
			begin
				idx = line * 4 + j;
				if (idx < rowCount)
				begin
					instruction[j * 64 +: 64] = {rows[idx].instrB, rows[idx].instrA};
				end
			end
		end
		@(posedge clock);
		#2;
		icacheWriteEnable = 1'b0;
	endtask

	////////////////////////////////////////
	// run control

	initial
	begin
		reset = 1'b1;
		icacheWriteEnable = 1'b0;
		writeLine = '0;
		instruction = '0;
		lfsrState = 32'h09ea4a2a;
		buildTable();
		modelTable();
		for (int i = 0; i < rowCount; i++)
		begin
			i_checker.expectRow(rows[i].expectA, rows[i].expectB);
		end
		fork
			loadCache();
			begin
				repeat (resetCycles) @(posedge clock);
				#2;
				reset = 1'b0;
			end
		join
		wait (rowsChecked == rowCount);
		$display("rows checked %0d, rows failed %0d, errors %0d",
			rowsChecked, rowsFailed, errorCount);
		if (errorCount == 0 && rowsFailed == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog limit set by the cache load which outlasts the rows
	initial
	begin
		#((`CACHE_LINES + rowCount + pipeDepth + resetCycles + marginCycles) * 20);
		$display("timeout: only %0d of %0d rows came back", rowsChecked, rowCount);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- project.f
+incdir+hw
hw/paIsaPkg.sv
hw/paPipePkg.sv
hw/instrCache.sv
hw/bundleFetch.sv
hw/bundleParser.sv
hw/laneDecode.sv
hw/registerFile.sv
hw/arithmeticUnit.sv
hw/paCore.sv
tests/paCoreChecker.sv
tests/paCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP := paCoreTb
FILELIST := project.f
FLAGS := --binary --timing -Wno-fatal
OBJDIR := obj_dir
PASS_TEXT := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)
